// ==== Makefile ====
# Verilator build of the tile video testbench

VERILATOR ?= verilator
TOP       ?= video_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -j 0
# Lets the testbench see assertion failures and end the run itself
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== common/cpu_bus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU bus and palette words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "video_params.svh"

package cpu_bus_pkg;

    typedef struct packed {
        logic [`VID_CHAR_AW-1:0] addr;
        logic [15:0]             data;
        logic [1:0]              dsn;
    } cpu_wr_t;

    typedef struct packed {
        logic       shade;
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } pal_rgb_t;

    typedef union packed {
        logic [15:0] raw;
        pal_rgb_t    rgb;
    } pal_word_u;

    // Byte lanes with dsn low take the CPU data
    function automatic logic [15:0] byte_merge(logic [15:0] old, cpu_wr_t wr);
        byte_merge = old;
        if (!wr.dsn[1]) byte_merge[15:8] = wr.data[15:8];
        if (!wr.dsn[0]) byte_merge[7:0] = wr.data[7:0];
    endfunction

endpackage

// ==== common/video_params.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video raster and memory sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// Raster geometry in pixels and lines
`define VID_HTOTAL     512
`define VID_VTOTAL     262
`define VID_HB_START   9'd320
`define VID_HB_END     9'd0
`define VID_VB_START   9'd224
`define VID_VB_END     9'd0
`define VID_HS_START   9'd384
`define VID_HS_LEN     9'd32
`define VID_VS_START   9'd240
`define VID_VS_LEN     9'd3
`define VID_VINT_LINE  9'd223

// Pipeline depth and RAM address widths
`define VID_MIX_DLY    2
`define VID_CHAR_AW    11
`define VID_PAL_AW     11

`endif

// ==== common/video_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Raster and layer pixel types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package video_pkg;

    // Counters and decoded raster state from the timer
    typedef struct packed {
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic [8:0] vrender;
        logic       hblank_n;
        logic       vblank_n;
        logic       hsync;
        logic       vsync;
    } raster_t;

    // Index 0 is transparent in both layers
    typedef struct packed {
        logic [2:0] bank;
        logic [3:0] idx;
    } char_pxl_t;

    typedef struct packed {
        logic       prio;
        logic [5:0] bank;
        logic [3:0] idx;
    } scr_pxl_t;

endpackage

// ==== compile.f ====
+incdir+common
common/video_pkg.sv
common/cpu_bus_pkg.sv
src/video_timer.sv
src/video_mmr.sv
tile/char_layer.sv
tile/scroll_layer.sv
src/color_mix.sv
src/video_top.sv
testbench/video_checker.sv
testbench/video_tb.sv

// ==== src/color_mix.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Palette and layer mixer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "video_params.svh"

module color_mix (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pxl_cen,
    input  logic                 video_en,
    input  logic                 pal_cs,
    input  cpu_bus_pkg::cpu_wr_t cpu_wr,
    output logic [15:0]          pal_dout,
    input  video_pkg::raster_t   raster,
    input  video_pkg::char_pxl_t char_pxl,
    input  video_pkg::scr_pxl_t  scr_pxl,
    output logic [4:0]           red,
    output logic [4:0]           green,
    output logic [4:0]           blue,
    output logic                 hblank_dly_n,
    output logic                 vblank_dly_n
);
    localparam int DLY = `VID_MIX_DLY;
    localparam int AW  = `VID_PAL_AW;

    cpu_bus_pkg::pal_word_u pal_ram [2**AW];
    cpu_bus_pkg::pal_word_u pal_q;
    logic [AW-1:0]          sel_addr;
    logic [AW-1:0]          addr_pipe [DLY-1];
    logic [DLY-1:0]         hb_pipe;
    logic [DLY-1:0]         vb_pipe;
    logic                   show;

    always_ff @(posedge clk) begin
        if (pal_cs) begin
            pal_ram[cpu_wr.addr[AW-1:0]].raw <=
                cpu_bus_pkg::byte_merge(pal_ram[cpu_wr.addr[AW-1:0]].raw, cpu_wr);
        end
    end

    assign pal_dout = pal_ram[cpu_wr.addr[AW-1:0]].raw;

    // Char over scroll over backdrop at entry 0
    always_comb begin
        if (char_pxl.idx != 4'd0) sel_addr = AW'(char_pxl);
        else if (scr_pxl.idx != 4'd0) sel_addr = AW'({1'b1, scr_pxl.bank, scr_pxl.idx});
        else sel_addr = '0;
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            addr_pipe[0] <= sel_addr;
            for (int i = 1; i < DLY - 1; i++) addr_pipe[i] <= addr_pipe[i-1];
            pal_q <= pal_ram[addr_pipe[DLY-2]];
        end
    end

    // Blanking follows the colour through the same number of stages
    always_ff @(posedge clk) begin
        if (reset) begin
            hb_pipe <= '0;
            vb_pipe <= '0;
        end else if (pxl_cen) begin
            hb_pipe <= {hb_pipe[DLY-2:0], raster.hblank_n};
            vb_pipe <= {vb_pipe[DLY-2:0], raster.vblank_n};
        end
    end

    assign hblank_dly_n = hb_pipe[DLY-1];
    assign vblank_dly_n = vb_pipe[DLY-1];
    assign show  = hblank_dly_n && vblank_dly_n && video_en;
    assign red   = show ? pal_q.rgb.red : 5'd0;
    assign green = show ? pal_q.rgb.green : 5'd0;
    assign blue  = show ? pal_q.rgb.blue : 5'd0;

endmodule

// ==== src/video_mmr.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scroll registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module video_mmr (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mmr_cs,
    input  cpu_bus_pkg::cpu_wr_t cpu_wr,
    output logic [15:0]          scr_pages,
    output logic [15:0]          scr_hpos,
    output logic [15:0]          scr_vpos
);
    // Word offsets, mirrored across the select window
    localparam logic [1:0] PAGES_OFS = 2'd0;
    localparam logic [1:0] HPOS_OFS  = 2'd1;
    localparam logic [1:0] VPOS_OFS  = 2'd2;

    always_ff @(posedge clk) begin
        if (reset) begin
            scr_pages <= 16'd0;
            scr_hpos  <= 16'd0;
            scr_vpos  <= 16'd0;
        end else if (mmr_cs) begin
            case (cpu_wr.addr[1:0])
                PAGES_OFS: scr_pages <= cpu_bus_pkg::byte_merge(scr_pages, cpu_wr);
                HPOS_OFS:  scr_hpos  <= cpu_bus_pkg::byte_merge(scr_hpos, cpu_wr);
                VPOS_OFS:  scr_vpos  <= cpu_bus_pkg::byte_merge(scr_vpos, cpu_wr);
                default: begin
                    // Unused slot
                end
            endcase
        end
    end

endmodule

// ==== src/video_timer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Raster timer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "video_params.svh"

module video_timer (
    input  logic               clk,
    input  logic               reset,
    input  logic               pxl_cen,
    output video_pkg::raster_t raster,
    output logic               vint
);
    localparam logic [8:0] HLAST = 9'(`VID_HTOTAL - 1);
    localparam logic [8:0] VLAST = 9'(`VID_VTOTAL - 1);

    logic [8:0] hdump;
    logic [8:0] vdump;
    logic [8:0] h_nxt;
    logic [8:0] v_nxt;
    logic       hblank_n;
    logic       vblank_n;

    always_comb begin
        h_nxt = (hdump == HLAST) ? 9'd0 : hdump + 9'd1;
        v_nxt = vdump;
        if (hdump == HLAST) begin
            v_nxt = (vdump == VLAST) ? 9'd0 : vdump + 9'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hdump    <= 9'd0;
            vdump    <= 9'd0;
            // Count restarts at the top left corner of the visible window
            hblank_n <= 1'b1;
            vblank_n <= 1'b1;
        end else if (pxl_cen) begin
            hdump <= h_nxt;
            vdump <= v_nxt;
            if (h_nxt == `VID_HB_START) hblank_n <= 1'b0;
            else if (h_nxt == `VID_HB_END) hblank_n <= 1'b1;
            // Vertical blanking only moves on a line change
            if (hdump == HLAST) begin
                if (v_nxt == `VID_VB_START) vblank_n <= 1'b0;
                else if (v_nxt == `VID_VB_END) vblank_n <= 1'b1;
            end
        end
    end

    always_comb begin
        raster.hdump    = hdump;
        raster.vdump    = vdump;
        raster.vrender  = (vdump == VLAST) ? 9'd0 : vdump + 9'd1;
        raster.hblank_n = hblank_n;
        raster.vblank_n = vblank_n;
        raster.hsync    = hdump >= `VID_HS_START && hdump < `VID_HS_START + `VID_HS_LEN;
        raster.vsync    = vdump >= `VID_VS_START && vdump < `VID_VS_START + `VID_VS_LEN;
    end

    // Counters sit on this spot for exactly one pxl_cen
    assign vint = pxl_cen && hdump == 9'd0 && vdump == `VID_VINT_LINE;

endmodule

// ==== src/video_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile video top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module video_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pxl_cen,
    input  logic                 video_en,
    input  logic                 char_cs,
    input  logic                 mmr_cs,
    input  logic                 pal_cs,
    input  cpu_bus_pkg::cpu_wr_t cpu_wr,
    output logic [15:0]          char_dout,
    output logic [15:0]          pal_dout,
    output logic                 vint,
    output logic [12:0]          char_addr,
    input  logic [31:0]          char_data,
    input  logic                 char_ok,
    output logic [14:0]          map_addr,
    input  logic [15:0]          map_data,
    input  logic                 map_ok,
    output logic [16:0]          scr_addr,
    input  logic [31:0]          scr_data,
    input  logic                 scr_ok,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 hblank_dly_n,
    output logic                 vblank_dly_n,
    output logic [4:0]           red,
    output logic [4:0]           green,
    output logic [4:0]           blue
);
    video_pkg::raster_t   raster;
    video_pkg::char_pxl_t char_pxl;
    video_pkg::scr_pxl_t  scr_pxl;
    logic [15:0]          scr_pages;
    logic [15:0]          scr_hpos;
    logic [15:0]          scr_vpos;

    // Sync straight from the counters
    assign hsync = raster.hsync;
    assign vsync = raster.vsync;

    video_timer u_timer (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .pxl_cen ( pxl_cen ),
        .raster  ( raster  ),
        .vint    ( vint    )
    );

    video_mmr u_mmr (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .mmr_cs    ( mmr_cs    ),
        .cpu_wr    ( cpu_wr    ),
        .scr_pages ( scr_pages ),
        .scr_hpos  ( scr_hpos  ),
        .scr_vpos  ( scr_vpos  )
    );

    char_layer u_char (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .char_cs   ( char_cs   ),
        .cpu_wr    ( cpu_wr    ),
        .char_dout ( char_dout ),
        .raster    ( raster    ),
        .char_addr ( char_addr ),
        .char_data ( char_data ),
        .char_ok   ( char_ok   ),
        .pxl       ( char_pxl  )
    );

    scroll_layer u_scr (
        .clk      ( clk       ),
        .reset    ( reset     ),
        .pxl_cen  ( pxl_cen   ),
        .raster   ( raster    ),
        .pages    ( scr_pages ),
        .hscr     ( scr_hpos  ),
        .vscr     ( scr_vpos  ),
        .map_addr ( map_addr  ),
        .map_data ( map_data  ),
        .map_ok   ( map_ok    ),
        .scr_addr ( scr_addr  ),
        .scr_data ( scr_data  ),
        .scr_ok   ( scr_ok    ),
        .pxl      ( scr_pxl   )
    );

    color_mix u_colmix (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .pxl_cen      ( pxl_cen      ),
        .video_en     ( video_en     ),
        .pal_cs       ( pal_cs       ),
        .cpu_wr       ( cpu_wr       ),
        .pal_dout     ( pal_dout     ),
        .raster       ( raster       ),
        .char_pxl     ( char_pxl     ),
        .scr_pxl      ( scr_pxl      ),
        .red          ( red          ),
        .green        ( green        ),
        .blue         ( blue         ),
        .hblank_dly_n ( hblank_dly_n ),
        .vblank_dly_n ( vblank_dly_n )
    );

endmodule

// ==== testbench/video_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sync and colour assertions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module video_checker (
    input logic       clk,
    input logic       reset,
    input logic       vint,
    input logic       hsync,
    input logic       hblank_n,
    input logic       hblank_dly_n,
    input logic       vblank_dly_n,
    input logic [4:0] red,
    input logic [4:0] green,
    input logic [4:0] blue
);
    int unsigned fail_count = 0;

    // Interrupt strobe is a single clock wide
    vint_one_clk: assert property (@(posedge clk) disable iff (reset) vint |=> !vint)
        else begin
            fail_count++;
            $error("vint stayed high for more than one clock");
        end

    // Sync pulse sits inside horizontal blanking
    hsync_in_blank: assert property (@(posedge clk) disable iff (reset)
        $rose(hsync) |-> !hblank_n)
        else begin
            fail_count++;
            $error("hsync rose outside horizontal blanking");
        end

    colour_muted: assert property (@(posedge clk) disable iff (reset)
        !(hblank_dly_n && vblank_dly_n) |-> (red == 5'd0 && green == 5'd0 && blue == 5'd0))
        else begin
            fail_count++;
            $error("colour not zero during delayed blanking");
        end

endmodule

bind video_top video_checker video_checker_inst (
    .clk          ( clk             ),
    .reset        ( reset           ),
    .vint         ( vint            ),
    .hsync        ( hsync           ),
    .hblank_n     ( raster.hblank_n ),
    .hblank_dly_n ( hblank_dly_n    ),
    .vblank_dly_n ( vblank_dly_n    ),
    .red          ( red             ),
    .green        ( green           ),
    .blue         ( blue            )
);

// ==== testbench/video_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile video testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "video_params.svh"

module video_tb;
    localparam logic [31:0] SEED       = 32'h5922;
    localparam int          LINE_CLKS  = 2 * `VID_HTOTAL;
    localparam int          FRAME_CLKS = LINE_CLKS * `VID_VTOTAL;
    localparam int          WRITE_CLKS = 1024;
    // Clocks per frame with both delayed blanking bits high
    localparam int          VISIBLE_CLKS = 2 * (`VID_HB_START - `VID_HB_END)
                                             * (`VID_VB_START - `VID_VB_END);
    // Raster test spans up to two frames, each video test one more
    localparam int          TIMEOUT_NS = 20 * (5 * FRAME_CLKS + WRITE_CLKS);
    localparam logic [1:0]  SEL_CHAR   = 2'd1;
    localparam logic [1:0]  SEL_PAL    = 2'd2;
    localparam logic [1:0]  SEL_MMR    = 2'd3;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 pxl_cen = 1'b0;
    logic                 cen_run;
    logic                 video_en;
    logic                 char_cs;
    logic                 mmr_cs;
    logic                 pal_cs;
    cpu_bus_pkg::cpu_wr_t cpu_wr;
    logic [15:0]          char_dout;
    logic [15:0]          pal_dout;
    logic                 vint;
    logic [12:0]          char_addr;
    logic [31:0]          char_data = 32'd0;
    logic                 char_ok = 1'b0;
    logic [14:0]          map_addr;
    logic [15:0]          map_data = 16'd0;
    logic                 map_ok = 1'b0;
    logic [16:0]          scr_addr;
    logic [31:0]          scr_data = 32'd0;
    logic                 scr_ok = 1'b0;
    logic                 hsync;
    logic                 vsync;
    logic                 hblank_dly_n;
    logic                 vblank_dly_n;
    logic [4:0]           red;
    logic [4:0]           green;
    logic [4:0]           blue;

    logic                 rom_zero;
    logic [31:0]          stim_seed;
    logic [31:0]          rom_seed = SEED;
    logic [31:0]          char_last = 32'd0;
    logic [31:0]          map_last = 32'd0;
    logic [31:0]          scr_last = 32'd0;
    int                   char_wait = 0;
    int                   map_wait = 0;
    int                   scr_wait = 0;
    logic [15:0]          backdrop;
    logic [15:0]          r;
    int                   shown;

    video_top video_top_inst (.*);

    always #10 clk = ~clk;

    // Pixel strobe on every second clock once the raster runs
    always @(negedge clk) begin
        pxl_cen <= cen_run && !pxl_cen;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] next_rand();
        stim_seed = lcg_next(stim_seed);
        return stim_seed[31:16];
    endfunction

    // Every address bit reaches the data word
    function automatic logic [31:0] rom_word(input logic [31:0] a);
        if (rom_zero) return 32'd0;
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    task automatic abort_run(input string reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            abort_run("value mismatch");
        end
    endtask

    // New address drops ok, which returns 1 to 4 clocks later
    task automatic answer_rom(input logic [31:0] addr, inout logic [31:0] last,
                              inout int wait_cnt, inout logic ok, input logic [1:0] dly);
        if (addr !== last) begin
            last     = addr;
            ok       = 1'b0;
            wait_cnt = int'(dly) + 1;
        end else if (wait_cnt > 1) begin
            wait_cnt--;
        end else begin
            ok = 1'b1;
        end
    endtask

    always @(negedge clk) begin
        rom_seed = lcg_next(rom_seed);
        answer_rom(32'(char_addr), char_last, char_wait, char_ok, rom_seed[17:16]);
        answer_rom(32'(map_addr), map_last, map_wait, map_ok, rom_seed[21:20]);
        answer_rom(32'(scr_addr), scr_last, scr_wait, scr_ok, rom_seed[25:24]);
        char_data = rom_word(32'(char_addr));
        map_data  = 16'(rom_word(32'(map_addr)));
        scr_data  = rom_word(32'(scr_addr));
    end

    task automatic bus_write(input logic [1:0] sel, input logic [10:0] addr,
                             input logic [15:0] data, input logic [1:0] dsn);
        @(negedge clk);
        cpu_wr.addr = addr;
        cpu_wr.data = data;
        cpu_wr.dsn  = dsn;
        char_cs     = sel == SEL_CHAR;
        pal_cs      = sel == SEL_PAL;
        mmr_cs      = sel == SEL_MMR;
        @(negedge clk);
        char_cs = 1'b0;
        pal_cs  = 1'b0;
        mmr_cs  = 1'b0;
    endtask

    task automatic bus_read(input logic [1:0] sel, input logic [10:0] addr,
                            output logic [15:0] data);
        @(negedge clk);
        cpu_wr.addr = addr;
        @(posedge clk);
        data = (sel == SEL_PAL) ? pal_dout : char_dout;
    endtask

    task automatic ram_test(input logic [1:0] sel, input string name);
        logic [10:0] addrs [16];
        logic [15:0] model [16];
        logic [15:0] data;
        logic [15:0] rnd;
        logic [15:0] rd;
        int          k;
        // Full word first so that every model entry is known
        for (int i = 0; i < 16; i++) begin
            rnd      = next_rand();
            addrs[i] = {4'(i), rnd[6:0]};
            model[i] = next_rand();
            bus_write(sel, addrs[i], model[i], 2'b00);
        end
        for (int n = 0; n < 64; n++) begin
            rnd  = next_rand();
            k    = int'(rnd[3:0]);
            data = next_rand();
            bus_write(sel, addrs[k], data, rnd[9:8]);
            if (!rnd[9]) model[k][15:8] = data[15:8];
            if (!rnd[8]) model[k][7:0] = data[7:0];
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(sel, addrs[i], rd);
            check_value(name, 32'(model[i]), 32'(rd));
        end
    endtask

    task automatic check_raster();
        int   cen_cnt;
        int   line_cnt;
        int   vint_cnt;
        logic hs_q;
        logic vs_q;
        logic hs_seen;
        logic vs_seen;
        logic done;
        cen_cnt  = 0;
        line_cnt = 0;
        vint_cnt = 0;
        hs_seen  = 1'b0;
        vs_seen  = 1'b0;
        done     = 1'b0;
        hs_q     = hsync;
        vs_q     = vsync;
        while (!done) begin
            @(posedge clk);
            if (pxl_cen) cen_cnt++;
            if (vint) vint_cnt++;
            if (hsync && !hs_q) begin
                if (hs_seen) check_value("hsync period", `VID_HTOTAL, 32'(cen_cnt));
                hs_seen = 1'b1;
                cen_cnt = 0;
                line_cnt++;
            end
            // Line and interrupt counts close at each vsync rise
            if (vsync && !vs_q) begin
                if (vs_seen) begin
                    check_value("vsync period", `VID_VTOTAL, 32'(line_cnt));
                    check_value("vint", 32'd1, 32'(vint_cnt));
                    done = 1'b1;
                end
                vs_seen  = 1'b1;
                line_cnt = 0;
                vint_cnt = 0;
            end
            hs_q = hsync;
            vs_q = vsync;
        end
    endtask

    always @(posedge clk) begin
        if (video_top_inst.video_checker_inst.fail_count != 0) begin
            abort_run("an assertion in video_checker failed");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        reset     = 1'b1;
        cen_run   = 1'b0;
        video_en  = 1'b0;
        char_cs   = 1'b0;
        mmr_cs    = 1'b0;
        pal_cs    = 1'b0;
        cpu_wr    = '0;
        rom_zero  = 1'b0;
        stim_seed = SEED;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Quiet outputs before the first pixel strobe
        @(posedge clk);
        check_value("hsync", 32'd0, 32'(hsync));
        check_value("vsync", 32'd0, 32'(vsync));
        check_value("vint", 32'd0, 32'(vint));
        check_value("red", 32'd0, 32'(red));
        check_value("green", 32'd0, 32'(green));
        check_value("blue", 32'd0, 32'(blue));

        ram_test(SEL_PAL, "pal_dout");
        ram_test(SEL_CHAR, "char_dout");

        @(negedge clk);
        cen_run <= 1'b1;
        check_raster();

        // Both layers transparent, so only palette entry 0 shows
        @(negedge clk);
        rom_zero <= 1'b1;
        backdrop = next_rand();
        bus_write(SEL_PAL, 11'd0, backdrop, 2'b00);
        for (int i = 0; i < 3; i++) begin
            r = next_rand();
            bus_write(SEL_MMR, 11'(i), next_rand(), r[1:0]);
        end
        video_en = 1'b1;
        repeat (2 * LINE_CLKS) @(posedge clk);
        shown = 0;
        repeat (FRAME_CLKS) begin
            @(posedge clk);
            if (hblank_dly_n && vblank_dly_n) begin
                shown++;
                check_value("red", 32'(backdrop[4:0]), 32'(red));
                check_value("green", 32'(backdrop[9:5]), 32'(green));
                check_value("blue", 32'(backdrop[14:10]), 32'(blue));
            end
        end
        check_value("hblank_dly_n & vblank_dly_n", VISIBLE_CLKS, 32'(shown));

        @(negedge clk);
        video_en = 1'b0;
        repeat (FRAME_CLKS) begin
            @(posedge clk);
            check_value("red", 32'd0, 32'(red));
            check_value("green", 32'd0, 32'(green));
            check_value("blue", 32'd0, 32'(blue));
        end

        if (video_top_inst.video_checker_inst.fail_count != 0) begin
            abort_run("an assertion in video_checker failed");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== tile/char_layer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Character layer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "video_params.svh"

module char_layer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pxl_cen,
    input  logic                 char_cs,
    input  cpu_bus_pkg::cpu_wr_t cpu_wr,
    output logic [15:0]          char_dout,
    input  video_pkg::raster_t   raster,
    output logic [12:0]          char_addr,
    input  logic [31:0]          char_data,
    input  logic                 char_ok,
    output video_pkg::char_pxl_t pxl
);
    logic [15:0] char_ram [2**`VID_CHAR_AW];
    logic [15:0] code;
    logic [8:0]  hfetch;
    logic [8:0]  vline;
    logic        tile_start;
    logic        busy;
    logic        fetched;
    logic [31:0] fetch_row;
    logic [31:0] next_row;
    logic [31:0] shift;
    logic [2:0]  fetch_bank;
    logic [2:0]  next_bank;
    logic [2:0]  cur_bank;

    always_ff @(posedge clk) begin
        if (char_cs) begin
            char_ram[cpu_wr.addr] <= cpu_bus_pkg::byte_merge(char_ram[cpu_wr.addr], cpu_wr);
        end
    end

    assign char_dout = char_ram[cpu_wr.addr];

    // Tile two steps ahead, taken from the next line near the line end
    assign hfetch     = raster.hdump + 9'd16;
    assign vline      = (raster.hdump >= 9'(`VID_HTOTAL - 16)) ? raster.vrender : raster.vdump;
    assign code       = char_ram[{vline[7:3], hfetch[8:3]}];
    assign tile_start = pxl_cen && raster.hdump[2:0] == 3'd0;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            fetched <= 1'b0;
        end else if (tile_start) begin
            busy    <= 1'b1;
            fetched <= 1'b0;
        end else if (busy && char_ok) begin
            busy    <= 1'b0;
            fetched <= 1'b1;
        end
    end

    // ROM address held until ok
    always_ff @(posedge clk) begin
        if (tile_start) begin
            char_addr  <= {code[9:0], vline[2:0]};
            fetch_bank <= code[12:10];
        end
        if (busy && char_ok) fetch_row <= char_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            next_row  <= 32'd0;
            next_bank <= 3'd0;
            shift     <= 32'd0;
            cur_bank  <= 3'd0;
            pxl       <= '0;
        end else if (pxl_cen) begin
            if (raster.hdump[2:0] == 3'd0) begin
                // Late fetch gives a transparent tile
                next_row  <= fetched ? fetch_row : 32'd0;
                next_bank <= fetch_bank;
                shift     <= {next_row[27:0], 4'd0};
                cur_bank  <= next_bank;
                pxl       <= '{bank: next_bank, idx: next_row[31:28]};
            end else begin
                shift <= {shift[27:0], 4'd0};
                pxl   <= '{bank: cur_bank, idx: shift[31:28]};
            end
        end
    end

endmodule

// ==== tile/scroll_layer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scrolling background layer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "video_params.svh"

module scroll_layer (
    input  logic                clk,
    input  logic                reset,
    input  logic                pxl_cen,
    input  video_pkg::raster_t  raster,
    input  logic [15:0]         pages,
    input  logic [15:0]         hscr,
    input  logic [15:0]         vscr,
    output logic [14:0]         map_addr,
    input  logic [15:0]         map_data,
    input  logic                map_ok,
    output logic [16:0]         scr_addr,
    input  logic [31:0]         scr_data,
    input  logic                scr_ok,
    output video_pkg::scr_pxl_t pxl
);
    logic [9:0]  hpos;
    logic [9:0]  hfetch;
    logic [8:0]  vline;
    logic [8:0]  vpos;
    logic [3:0]  page;
    logic        tile_start;
    logic        map_busy;
    logic        scr_busy;
    logic        fetched;
    logic [2:0]  vfine;
    logic [15:0] map_word;
    logic [31:0] fetch_row;
    logic [31:0] next_row;
    logic [31:0] shift;
    logic [6:0]  next_attr;
    logic [6:0]  cur_attr;

    // World is 2x2 pages of 512x256
    assign hpos       = {1'b0, raster.hdump} + hscr[9:0];
    assign hfetch     = hpos + 10'd16;
    assign vline      = (raster.hdump >= 9'(`VID_HTOTAL - 16)) ? raster.vrender : raster.vdump;
    assign vpos       = vline + vscr[8:0];
    assign page       = pages[{vpos[8], hfetch[9], 2'b00} +: 4];
    assign tile_start = pxl_cen && hpos[2:0] == 3'd0;

    // Map word first, then the graphics row it points to
    always_ff @(posedge clk) begin
        if (reset) begin
            map_busy <= 1'b0;
            scr_busy <= 1'b0;
            fetched  <= 1'b0;
        end else if (tile_start) begin
            map_busy <= 1'b1;
            scr_busy <= 1'b0;
            fetched  <= 1'b0;
        end else if (map_busy && map_ok) begin
            map_busy <= 1'b0;
            scr_busy <= 1'b1;
        end else if (scr_busy && scr_ok) begin
            scr_busy <= 1'b0;
            fetched  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tile_start) begin
            map_addr <= {page, vpos[7:3], hfetch[8:3]};
            vfine    <= vpos[2:0];
        end
        if (map_busy && map_ok) begin
            map_word <= map_data;
            scr_addr <= {map_data[13:0], vfine};
        end
        if (scr_busy && scr_ok) fetch_row <= scr_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            next_row  <= 32'd0;
            next_attr <= 7'd0;
            shift     <= 32'd0;
            cur_attr  <= 7'd0;
            pxl       <= '0;
        end else if (pxl_cen) begin
            if (hpos[2:0] == 3'd0) begin
                next_row  <= fetched ? fetch_row : 32'd0;
                next_attr <= {map_word[15], map_word[11:6]};
                shift     <= {next_row[27:0], 4'd0};
                cur_attr  <= next_attr;
                pxl       <= {next_attr, next_row[31:28]};
            end else begin
                shift <= {shift[27:0], 4'd0};
                pxl   <= {cur_attr, shift[31:28]};
            end
        end
    end

endmodule
